// ==== Makefile ====
# Verilator build and run of the coherence directory testbench

VERILATOR ?= verilator
TOP       ?= tb_cce
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
ERR_LIMIT ?= 100
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FAIL_MSG := FAIL: see errors above
PASS_MSG := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG ERR_LIMIT VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERR_LIMIT) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Result: failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Result: run did not finish"; exit 1; fi
	@echo "Result: passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== include/cce_cfg.svh ====
// Coherence directory configuration: system sizes and MSI state and command encodings
`ifndef CCE_CFG_SVH
`define CCE_CFG_SVH

// Number of cache engines served by this home node
`define CCE_NUM_LCE 4

// Block address width, index taken from the low bits
`define CCE_ADDR_W 16

// Directory sets per LCE slice
`define CCE_SETS 8

// MSI coherence states
`define CCE_ST_I 2'd0
`define CCE_ST_S 2'd1
`define CCE_ST_M 2'd2

// Commands sent to the LCEs
`define CCE_CMD_INV 2'd0
`define CCE_CMD_GRANT_S 2'd1
`define CCE_CMD_GRANT_M 2'd2

`endif

// ==== tests/cce_checker.sv ====
// Protocol checker that watches command stability, reset and ready exclusion of the engine
`default_nettype none

`include "cce_cfg.svh"

module cce_checker
  import cce_pkg::*;
  (input wire                       clk_i
   , input wire                     rst_n_i
   , input wire                     req_ready_i
   , input wire                     resp_ready_i
   , input wire                     cmd_v_i
   , input wire                     cmd_ready_i
   , input wire [1:0]               cmd_type_i
   , input wire [LCE_ID_W-1:0]      cmd_lce_i
   , input wire [`CCE_ADDR_W-1:0]   cmd_addr_i
  );

  // Count of failed assertions
  int fail_count = 0;

  // A stalled command keeps all its fields
  cmd_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cmd_v_i && !cmd_ready_i) |=> (cmd_v_i && $stable(cmd_type_i)
                                   && $stable(cmd_lce_i) && $stable(cmd_addr_i)))
    else begin
      $error("command changed while stalled");
      fail_count++;
    end

  cmd_reset: assert property (@(posedge clk_i) !rst_n_i |=> !cmd_v_i)
    else begin
      $error("command valid during reset");
      fail_count++;
    end

  // Idle and ack wait never overlap
  ready_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(req_ready_i && resp_ready_i))
    else begin
      $error("request and response ready both high");
      fail_count++;
    end

endmodule

bind cce_top cce_checker chk (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .req_ready_i  (lce_req_ready_o),
  .resp_ready_i (lce_resp_ready_o),
  .cmd_v_i      (lce_cmd_v_o),
  .cmd_ready_i  (lce_cmd_ready_i),
  .cmd_type_i   (lce_cmd_type_o),
  .cmd_lce_i    (lce_cmd_lce_o),
  .cmd_addr_i   (lce_cmd_addr_o)
);

`default_nettype wire

// ==== tests/tb_cce.sv ====
// Directed testbench for the coherence engine with an LCE model that acks invalidations
`default_nettype none

`include "cce_cfg.svh"

module tb_cce
  import cce_pkg::*;
  ();

  localparam int TIMEOUT = 200;

  logic                   clk_i = 1'b0;
  logic                   rst_n_i;
  logic                   lce_req_v_i;
  logic [LCE_ID_W-1:0]    lce_req_lce_i;
  logic                   lce_req_write_i;
  logic [`CCE_ADDR_W-1:0] lce_req_addr_i;
  logic                   lce_req_ready_o;
  logic                   lce_resp_v_i;
  logic [LCE_ID_W-1:0]    lce_resp_lce_i;
  logic [`CCE_ADDR_W-1:0] lce_resp_addr_i;
  logic                   lce_resp_ready_o;
  logic                   lce_cmd_v_o;
  logic [1:0]             lce_cmd_type_o;
  logic [LCE_ID_W-1:0]    lce_cmd_lce_o;
  logic [`CCE_ADDR_W-1:0] lce_cmd_addr_o;
  logic                   lce_cmd_ready_i = 1'b1;

  // Commands seen on the channel in order
  logic [1:0]             seen_type_q [$];
  logic [LCE_ID_W-1:0]    seen_lce_q [$];
  logic [`CCE_ADDR_W-1:0] seen_addr_q [$];

  int seed = 34;
  int mismatches;
  int failures;
  bit bp_en;
  int bp_span = 0;

  cce_top dut (.*);

  always #10 clk_i = ~clk_i;

  // Record each command on the edge before it is taken
  always @(negedge clk_i) begin
    if (rst_n_i && lce_cmd_v_o && lce_cmd_ready_i) begin
      seen_type_q.push_back(lce_cmd_type_o);
      seen_lce_q.push_back(lce_cmd_lce_o);
      seen_addr_q.push_back(lce_cmd_addr_o);
    end
  end

  // Random stall spans on the command channel
  always @(posedge clk_i) begin
    if (!bp_en) begin
      lce_cmd_ready_i <= 1'b1;
    end else if (bp_span == 0) begin
      lce_cmd_ready_i <= !lce_cmd_ready_i;
      bp_span <= $random(seed) & 7;
    end else begin
      bp_span <= bp_span - 1;
    end
  end

  task automatic check_cmd(input string test, input logic [1:0] exp_type,
                           input logic [LCE_ID_W-1:0] exp_lce,
                           input logic [`CCE_ADDR_W-1:0] exp_addr,
                           input logic [1:0] act_type, input logic [LCE_ID_W-1:0] act_lce,
                           input logic [`CCE_ADDR_W-1:0] act_addr);
    if (act_type !== exp_type || act_lce !== exp_lce || act_addr !== exp_addr) begin
      mismatches++;
      $display("Mismatch %s: expected type %0d lce %0d addr %h, actual type %0d lce %0d addr %h",
               test, exp_type, exp_lce, exp_addr, act_type, act_lce, act_addr);
    end
  endtask

  task automatic check_bit(input string test, input string what, input logic exp,
                           input logic act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch %s %s: expected %b, actual %b", test, what, exp, act);
    end
  endtask

  task automatic send_req(input string test, input logic [LCE_ID_W-1:0] lce,
                          input logic write, input logic [`CCE_ADDR_W-1:0] addr);
    int waited;
    waited = 0;
    @(posedge clk_i);
    lce_req_v_i     <= 1'b1;
    lce_req_lce_i   <= lce;
    lce_req_write_i <= write;
    lce_req_addr_i  <= addr;
    @(negedge clk_i);
    while (!lce_req_ready_o && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!lce_req_ready_o) begin
      failures++;
      $display("%s: request from LCE %0d was never accepted", test, lce);
    end
    @(posedge clk_i);
    lce_req_v_i <= 1'b0;
  endtask

  // LCE side acks one invalidation after a random delay
  task automatic answer_inv(input string test, input logic [LCE_ID_W-1:0] lce,
                            input logic [`CCE_ADDR_W-1:0] addr);
    int delay;
    int waited;
    @(negedge clk_i);
    delay = $random(seed) & 3;
    repeat (delay) @(posedge clk_i);
    @(posedge clk_i);
    lce_resp_v_i    <= 1'b1;
    lce_resp_lce_i  <= lce;
    lce_resp_addr_i <= addr;
    waited = 0;
    @(negedge clk_i);
    while (!lce_resp_ready_o && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!lce_resp_ready_o) begin
      failures++;
      $display("%s: ack from LCE %0d was never accepted", test, lce);
    end
    @(posedge clk_i);
    lce_resp_v_i <= 1'b0;
  endtask

  task automatic expect_cmd(input string test, input logic [1:0] exp_type,
                            input logic [LCE_ID_W-1:0] exp_lce,
                            input logic [`CCE_ADDR_W-1:0] exp_addr);
    int waited;
    logic [1:0]             act_type;
    logic [LCE_ID_W-1:0]    act_lce;
    logic [`CCE_ADDR_W-1:0] act_addr;
    waited = 0;
    @(posedge clk_i);
    while (seen_type_q.size() == 0 && waited < TIMEOUT) begin
      @(posedge clk_i);
      waited++;
    end
    if (seen_type_q.size() == 0) begin
      failures++;
      $display("%s: no command arrived while waiting for one to LCE %0d", test, exp_lce);
    end else begin
      act_type = seen_type_q.pop_front();
      act_lce  = seen_lce_q.pop_front();
      act_addr = seen_addr_q.pop_front();
      check_cmd(test, exp_type, exp_lce, exp_addr, act_type, act_lce, act_addr);
      if (act_type == `CCE_CMD_INV) begin
        answer_inv(test, act_lce, act_addr);
      end
    end
  endtask

  // Wait for idle and check that no command beyond the expected ones was sent
  task automatic finish_txn(input string test);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!lce_req_ready_o && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!lce_req_ready_o) begin
      failures++;
      $display("%s: controller did not return to idle", test);
    end
    @(posedge clk_i);
    if (seen_type_q.size() != 0) begin
      failures++;
      $display("%s: %0d unexpected commands after the grant", test, seen_type_q.size());
      seen_type_q.delete();
      seen_lce_q.delete();
      seen_addr_q.delete();
    end
  endtask

  task automatic test_reset();
    @(negedge clk_i);
    check_bit("reset", "cmd valid", 1'b0, lce_cmd_v_o);
    check_bit("reset", "resp ready", 1'b0, lce_resp_ready_o);
    check_bit("reset", "req ready", 1'b1, lce_req_ready_o);
  endtask

  task automatic test_read_no_holders();
    int k;
    send_req("read_no_holders", 1, 1'b0, 16'h0123);
    // Grant is valid only after the third edge
    for (k = 0; k < 4; k++) begin
      @(negedge clk_i);
      check_bit("read_no_holders", $sformatf("cmd valid after edge %0d", k), k == 3,
                lce_cmd_v_o);
    end
    expect_cmd("read_no_holders", `CCE_CMD_GRANT_S, 1, 16'h0123);
    finish_txn("read_no_holders");
  endtask

  task automatic test_write_sharers(input string test, input logic [`CCE_ADDR_W-1:0] addr);
    send_req(test, 0, 1'b0, addr);
    expect_cmd(test, `CCE_CMD_GRANT_S, 0, addr);
    finish_txn(test);
    send_req(test, 2, 1'b0, addr);
    expect_cmd(test, `CCE_CMD_GRANT_S, 2, addr);
    finish_txn(test);
    send_req(test, 3, 1'b1, addr);
    expect_cmd(test, `CCE_CMD_INV, 0, addr);
    expect_cmd(test, `CCE_CMD_INV, 2, addr);
    expect_cmd(test, `CCE_CMD_GRANT_M, 3, addr);
    finish_txn(test);
    // Owner is recalled before the new sharer
    send_req(test, 0, 1'b0, addr);
    expect_cmd(test, `CCE_CMD_INV, 3, addr);
    expect_cmd(test, `CCE_CMD_GRANT_S, 0, addr);
    finish_txn(test);
  endtask

  task automatic test_upgrade(input string test, input logic [`CCE_ADDR_W-1:0] addr);
    send_req(test, 1, 1'b0, addr);
    expect_cmd(test, `CCE_CMD_GRANT_S, 1, addr);
    finish_txn(test);
    send_req(test, 1, 1'b1, addr);
    expect_cmd(test, `CCE_CMD_GRANT_M, 1, addr);
    finish_txn(test);
  endtask

  task automatic test_back_pressure();
    @(negedge clk_i);
    bp_en = 1'b1;
    test_write_sharers("back_pressure", 16'h0c02);
    test_upgrade("back_pressure", 16'h0d04);
    @(negedge clk_i);
    bp_en = 1'b0;
  endtask

  // Both addresses map to set index 1 with different tags
  task automatic test_set_conflict();
    send_req("set_conflict", 2, 1'b0, 16'h1231);
    expect_cmd("set_conflict", `CCE_CMD_GRANT_S, 2, 16'h1231);
    finish_txn("set_conflict");
    send_req("set_conflict", 2, 1'b0, 16'h4561);
    expect_cmd("set_conflict", `CCE_CMD_GRANT_S, 2, 16'h4561);
    finish_txn("set_conflict");
    send_req("set_conflict", 0, 1'b1, 16'h1231);
    expect_cmd("set_conflict", `CCE_CMD_GRANT_M, 0, 16'h1231);
    finish_txn("set_conflict");
  endtask

  initial begin
    rst_n_i         = 1'b0;
    lce_req_v_i     = 1'b0;
    lce_req_lce_i   = '0;
    lce_req_write_i = 1'b0;
    lce_req_addr_i  = '0;
    lce_resp_v_i    = 1'b0;
    lce_resp_lce_i  = '0;
    lce_resp_addr_i = '0;
    bp_en           = 1'b0;
    mismatches      = 0;
    failures        = 0;
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;
    test_reset();
    test_read_no_holders();
    test_write_sharers("write_sharers", 16'h0a05);
    test_upgrade("upgrade", 16'h0b06);
    test_back_pressure();
    test_set_conflict();
    $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatches, failures, dut.chk.fail_count);
    if (mismatches + failures + dut.chk.fail_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
verilog/cce_pkg.sv
verilog/cce_dir_slice.sv
verilog/cce_gad.sv
verilog/cce_req_ctrl.sv
verilog/cce_top.sv
tests/cce_checker.sv
tests/tb_cce.sv

// ==== verilog/cce_dir_slice.sv ====
// Directory slice for one LCE: direct-mapped tag and state per set, synchronous lookup
`default_nettype none

`include "cce_cfg.svh"

module cce_dir_slice
  import cce_pkg::*;
  #(parameter int lce_id_p = 0)
  (input wire                      clk_i
   , input wire                    rst_n_i

   // Lookup and write, broadcast from the controller
   , input wire                    rd_v_i
   , input wire [IDX_W-1:0]        idx_i
   , input wire [TAG_W-1:0]        tag_i
   , input wire                    wr_v_i
   , input wire [`CCE_NUM_LCE-1:0] wr_mask_i
   , input wire [1:0]              wr_state_i

   // Lookup result, valid the cycle after rd_v_i
   , output logic                  hit_o
   , output logic [1:0]            state_o
  );

  localparam int SETS = `CCE_SETS;

  logic [TAG_W-1:0] tag_mem [SETS];
  logic [1:0]       state_mem [SETS];

  logic [TAG_W-1:0] rd_tag_q;
  logic [TAG_W-1:0] cmp_tag_q;
  logic [1:0]       rd_state_q;
  logic             wr_en;

  // Only this LCE's bit of the mask selects the slice
  assign wr_en = wr_v_i && wr_mask_i[lce_id_p];

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      tag_mem[idx_i] <= tag_i;
    end
  end

  // Every entry starts invalid
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int s = 0; s < SETS; s++) begin
        state_mem[s] <= `CCE_ST_I;
      end
    end else if (wr_en) begin
      state_mem[idx_i] <= wr_state_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_state_q <= `CCE_ST_I;
    end else if (rd_v_i) begin
      rd_state_q <= state_mem[idx_i];
    end
  end

  // Stored tag and lookup tag captured together
  always_ff @(posedge clk_i) begin
    if (rd_v_i) begin
      rd_tag_q  <= tag_mem[idx_i];
      cmp_tag_q <= tag_i;
    end
  end

  // A different tag in the set is a miss for this block
  assign hit_o   = (rd_state_q != `CCE_ST_I) && (rd_tag_q == cmp_tag_q);
  assign state_o = rd_state_q;

endmodule

`default_nettype wire

// ==== verilog/cce_gad.sv ====
// GAD reduction: turns per-LCE lookup results into sharer mask, M owner and requestor state
`default_nettype none

`include "cce_cfg.svh"

module cce_gad
  import cce_pkg::*;
  (input wire                         clk_i
   , input wire                       rst_n_i

   , input wire [`CCE_NUM_LCE-1:0]    hits_i
   , input wire [2*`CCE_NUM_LCE-1:0]  states_i
   , input wire [LCE_ID_W-1:0]        req_lce_i

   , output logic [`CCE_NUM_LCE-1:0]  sharer_mask_o
   , output logic                     owner_v_o
   , output logic [LCE_ID_W-1:0]      owner_lce_o
   , output logic [1:0]               req_state_o
  );

  localparam int N = `CCE_NUM_LCE;

  logic [1:0] req_state_d;

  // Walk downwards so the lowest index owner wins
  always_comb begin
    sharer_mask_o = '0;
    owner_v_o     = 1'b0;
    owner_lce_o   = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (hits_i[i] && (i != int'(req_lce_i))) begin
        if ((states_i[2*i +: 2] == `CCE_ST_S) || (states_i[2*i +: 2] == `CCE_ST_M)) begin
          sharer_mask_o[i] = 1'b1;
        end
        if (states_i[2*i +: 2] == `CCE_ST_M) begin
          owner_v_o   = 1'b1;
          owner_lce_o = LCE_ID_W'(i);
        end
      end
    end
  end

  // Requestor miss reads as I
  always_comb begin
    if (hits_i[req_lce_i]) begin
      req_state_d = states_i[{req_lce_i, 1'b0} +: 2];
    end else begin
      req_state_d = `CCE_ST_I;
    end
  end

  // Needed only at grant time, so it is taken off the lookup path
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_state_o <= `CCE_ST_I;
    end else begin
      req_state_o <= req_state_d;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/cce_pkg.sv ====
// Coherence directory package with derived field widths and block address split helpers
`default_nettype none

`include "cce_cfg.svh"

package cce_pkg;

  // LCE identifier width
  localparam int LCE_ID_W = $clog2(`CCE_NUM_LCE);

  // Set index and tag split of a block address
  localparam int IDX_W = $clog2(`CCE_SETS);
  localparam int TAG_W = `CCE_ADDR_W - IDX_W;

  // Ack counter has to reach the full LCE count
  localparam int CNT_W = LCE_ID_W + 1;

  // Set index from the low-order address bits
  function automatic logic [IDX_W-1:0] addr_index(
    input logic [`CCE_ADDR_W-1:0] addr
  );
    return addr[IDX_W-1:0];
  endfunction

  // Tag from the bits above the index
  function automatic logic [TAG_W-1:0] addr_tag(
    input logic [`CCE_ADDR_W-1:0] addr
  );
    return addr[`CCE_ADDR_W-1:IDX_W];
  endfunction

endpackage

`default_nettype wire

// ==== verilog/cce_req_ctrl.sv ====
// Request controller: holds one LCE request, runs the MSI transaction and drives the directory
`default_nettype none

`include "cce_cfg.svh"

module cce_req_ctrl
  import cce_pkg::*;
  (input wire                         clk_i
   , input wire                       rst_n_i

   // LCE request channel
   , input wire                       lce_req_v_i
   , input wire [LCE_ID_W-1:0]        lce_req_lce_i
   , input wire                       lce_req_write_i
   , input wire [`CCE_ADDR_W-1:0]     lce_req_addr_i
   , output logic                     lce_req_ready_o

   // LCE response channel, invalidation acks
   , input wire                       lce_resp_v_i
   , input wire [LCE_ID_W-1:0]        lce_resp_lce_i
   , input wire [`CCE_ADDR_W-1:0]     lce_resp_addr_i
   , output logic                     lce_resp_ready_o

   // LCE command channel
   , output logic                     lce_cmd_v_o
   , output logic [1:0]               lce_cmd_type_o
   , output logic [LCE_ID_W-1:0]      lce_cmd_lce_o
   , output logic [`CCE_ADDR_W-1:0]   lce_cmd_addr_o
   , input wire                       lce_cmd_ready_i

   // From the GAD
   , input wire [`CCE_NUM_LCE-1:0]    sharer_mask_i
   , input wire                       owner_v_i
   , input wire [LCE_ID_W-1:0]        owner_lce_i
   , input wire [1:0]                 req_state_i

   // To the slices and the GAD
   , output logic                     dir_rd_v_o
   , output logic [IDX_W-1:0]         dir_idx_o
   , output logic [TAG_W-1:0]         dir_tag_o
   , output logic                     dir_wr_v_o
   , output logic [`CCE_NUM_LCE-1:0]  dir_wr_mask_o
   , output logic [1:0]               dir_wr_state_o
   , output logic [LCE_ID_W-1:0]      req_lce_o
  );

  localparam int N = `CCE_NUM_LCE;

  localparam logic [2:0] ST_IDLE     = 3'd0;
  localparam logic [2:0] ST_READ     = 3'd1;
  localparam logic [2:0] ST_RESOLVE  = 3'd2;
  localparam logic [2:0] ST_INV      = 3'd3;
  localparam logic [2:0] ST_WAIT_ACK = 3'd4;
  localparam logic [2:0] ST_GRANT    = 3'd5;
  localparam logic [2:0] ST_UPDATE   = 3'd6;

  logic [2:0]             state_q;
  logic [2:0]             state_d;

  // Request header buffer
  logic [LCE_ID_W-1:0]    req_lce_q;
  logic                   req_write_q;
  logic [`CCE_ADDR_W-1:0] req_addr_q;

  logic [N-1:0]           inv_mask_q;
  logic [N-1:0]           inv_pend_q;
  logic [N-1:0]           inv_mask_d;
  logic [CNT_W-1:0]       sent_q;
  logic [CNT_W-1:0]       ack_q;
  logic [LCE_ID_W-1:0]    inv_lce;
  logic [N-1:0]           req_onehot;
  logic [1:0]             grant_state;
  logic                   req_fire;
  logic                   cmd_fire;
  logic                   ack_ok;

  assign req_fire = lce_req_v_i && lce_req_ready_o;
  assign cmd_fire = lce_cmd_v_o && lce_cmd_ready_i;

  // Only acks from an invalidated LCE for this block are counted
  assign ack_ok = lce_resp_v_i && lce_resp_ready_o && inv_mask_q[lce_resp_lce_i]
                  && (lce_resp_addr_i == req_addr_q);

  assign req_onehot  = N'(1) << req_lce_q;
  assign grant_state = req_write_q ? `CCE_ST_M : `CCE_ST_S;

  // Reads recall only an M owner, writes clear every other holder
  always_comb begin
    if (req_write_q) begin
      inv_mask_d = sharer_mask_i;
    end else if (owner_v_i) begin
      inv_mask_d = N'(1) << owner_lce_i;
    end else begin
      inv_mask_d = '0;
    end
  end

  // Lowest pending index goes out first
  always_comb begin
    inv_lce = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (inv_pend_q[i]) begin
        inv_lce = LCE_ID_W'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      req_lce_q   <= lce_req_lce_i;
      req_write_q <= lce_req_write_i;
      req_addr_q  <= lce_req_addr_i;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:     if (req_fire) state_d = ST_READ;
      ST_READ:     state_d = ST_RESOLVE;
      ST_RESOLVE:  state_d = ST_INV;
      ST_INV: begin
        // Empty mask only happens on entry
        if (inv_pend_q == '0) begin
          state_d = ST_GRANT;
        end else if (cmd_fire && ((inv_pend_q & (inv_pend_q - 1'b1)) == '0)) begin
          state_d = ST_WAIT_ACK;
        end
      end
      ST_WAIT_ACK: if (ack_q == sent_q) state_d = ST_GRANT;
      ST_GRANT:    if (cmd_fire) state_d = ST_UPDATE;
      ST_UPDATE:   state_d = ST_IDLE;
      default:     state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= ST_IDLE;
      inv_mask_q <= '0;
      inv_pend_q <= '0;
      sent_q     <= '0;
      ack_q      <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_RESOLVE) begin
        inv_mask_q <= inv_mask_d;
        inv_pend_q <= inv_mask_d;
        sent_q     <= '0;
        ack_q      <= '0;
      end else begin
        if (cmd_fire && (state_q == ST_INV)) begin
          inv_pend_q <= inv_pend_q & (inv_pend_q - 1'b1);
          sent_q     <= sent_q + 1'b1;
        end
        if (ack_ok) begin
          ack_q <= ack_q + 1'b1;
        end
      end
    end
  end

  assign lce_req_ready_o = (state_q == ST_IDLE);

  // Counters only differ while acks are outstanding
  assign lce_resp_ready_o = (ack_q != sent_q);

  // All command fields come from registers, so they hold under back-pressure
  assign lce_cmd_v_o    = ((state_q == ST_INV) && (inv_pend_q != '0)) || (state_q == ST_GRANT);
  assign lce_cmd_type_o = (state_q == ST_GRANT) ? (req_write_q ? `CCE_CMD_GRANT_M
                                                              : `CCE_CMD_GRANT_S)
                                                : `CCE_CMD_INV;
  assign lce_cmd_lce_o  = (state_q == ST_GRANT) ? req_lce_q : inv_lce;
  assign lce_cmd_addr_o = req_addr_q;

  assign dir_rd_v_o = (state_q == ST_READ);
  assign dir_idx_o  = addr_index(req_addr_q);
  assign dir_tag_o  = addr_tag(req_addr_q);
  assign req_lce_o  = req_lce_q;

  // Requestor entry on grant acceptance, then invalidated holders to I
  assign dir_wr_v_o     = ((state_q == ST_GRANT) && cmd_fire && (req_state_i != grant_state))
                          || ((state_q == ST_UPDATE) && (inv_mask_q != '0));
  assign dir_wr_mask_o  = (state_q == ST_UPDATE) ? inv_mask_q : req_onehot;
  assign dir_wr_state_o = (state_q == ST_UPDATE) ? `CCE_ST_I : grant_state;

endmodule

`default_nettype wire

// ==== verilog/cce_top.sv ====
// Coherence engine top: request controller, per-LCE directory slices and GAD reduction
`default_nettype none

`include "cce_cfg.svh"

module cce_top
  import cce_pkg::*;
  (input wire                       clk_i
   , input wire                     rst_n_i

   , input wire                     lce_req_v_i
   , input wire [LCE_ID_W-1:0]      lce_req_lce_i
   , input wire                     lce_req_write_i
   , input wire [`CCE_ADDR_W-1:0]   lce_req_addr_i
   , output logic                   lce_req_ready_o

   , input wire                     lce_resp_v_i
   , input wire [LCE_ID_W-1:0]      lce_resp_lce_i
   , input wire [`CCE_ADDR_W-1:0]   lce_resp_addr_i
   , output logic                   lce_resp_ready_o

   , output logic                   lce_cmd_v_o
   , output logic [1:0]             lce_cmd_type_o
   , output logic [LCE_ID_W-1:0]    lce_cmd_lce_o
   , output logic [`CCE_ADDR_W-1:0] lce_cmd_addr_o
   , input wire                     lce_cmd_ready_i
  );

  localparam int N = `CCE_NUM_LCE;

  // Controller to slices
  logic                dir_rd_v;
  logic [IDX_W-1:0]    dir_idx;
  logic [TAG_W-1:0]    dir_tag;
  logic                dir_wr_v;
  logic [N-1:0]        dir_wr_mask;
  logic [1:0]          dir_wr_state;
  logic [LCE_ID_W-1:0] req_lce;

  // Slices to GAD
  logic [N-1:0]        slice_hits;
  logic [2*N-1:0]      slice_states;

  // GAD to controller
  logic [N-1:0]        sharer_mask;
  logic                owner_v;
  logic [LCE_ID_W-1:0] owner_lce;
  logic [1:0]          req_hit_state;

  cce_req_ctrl ctrl (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .lce_req_v_i      (lce_req_v_i),
    .lce_req_lce_i    (lce_req_lce_i),
    .lce_req_write_i  (lce_req_write_i),
    .lce_req_addr_i   (lce_req_addr_i),
    .lce_req_ready_o  (lce_req_ready_o),
    .lce_resp_v_i     (lce_resp_v_i),
    .lce_resp_lce_i   (lce_resp_lce_i),
    .lce_resp_addr_i  (lce_resp_addr_i),
    .lce_resp_ready_o (lce_resp_ready_o),
    .lce_cmd_v_o      (lce_cmd_v_o),
    .lce_cmd_type_o   (lce_cmd_type_o),
    .lce_cmd_lce_o    (lce_cmd_lce_o),
    .lce_cmd_addr_o   (lce_cmd_addr_o),
    .lce_cmd_ready_i  (lce_cmd_ready_i),
    .sharer_mask_i    (sharer_mask),
    .owner_v_i        (owner_v),
    .owner_lce_i      (owner_lce),
    .req_state_i      (req_hit_state),
    .dir_rd_v_o       (dir_rd_v),
    .dir_idx_o        (dir_idx),
    .dir_tag_o        (dir_tag),
    .dir_wr_v_o       (dir_wr_v),
    .dir_wr_mask_o    (dir_wr_mask),
    .dir_wr_state_o   (dir_wr_state),
    .req_lce_o        (req_lce)
  );

  // One slice per LCE
  for (genvar g = 0; g < N; g++) begin : g_slice
    cce_dir_slice #(.lce_id_p(g)) slice (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .rd_v_i     (dir_rd_v),
      .idx_i      (dir_idx),
      .tag_i      (dir_tag),
      .wr_v_i     (dir_wr_v),
      .wr_mask_i  (dir_wr_mask),
      .wr_state_i (dir_wr_state),
      .hit_o      (slice_hits[g]),
      .state_o    (slice_states[2*g +: 2])
    );
  end

  cce_gad gad (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .hits_i        (slice_hits),
    .states_i      (slice_states),
    .req_lce_i     (req_lce),
    .sharer_mask_o (sharer_mask),
    .owner_v_o     (owner_v),
    .owner_lce_o   (owner_lce),
    .req_state_o   (req_hit_state)
  );

endmodule

`default_nettype wire
